// ==== design/i2c_defs.svh ====
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// Bus field widths
`define I2C_ADDR_WIDTH      7
`define I2C_REG_WIDTH       8
`define I2C_DATA_WIDTH      8

// Bit rate divider
`define I2C_DIVIDER_WIDTH   16

// Serial framing
`define I2C_BYTE_BITS       8
`define I2C_PHASE_COUNT     4

`endif

// ==== design/i2c_bus_pkg.sv ====
`include "i2c_defs.svh"

package i2c_bus_pkg;

    // 7-bit target address, no R/W bit
    typedef logic [`I2C_ADDR_WIDTH-1:0]    i2c_dev_addr_t;

    typedef logic [`I2C_REG_WIDTH-1:0]     i2c_reg_addr_t;

    typedef logic [`I2C_DATA_WIDTH-1:0]    i2c_data_t;

    // Clocks per phase, minus one
    typedef logic [`I2C_DIVIDER_WIDTH-1:0] i2c_divider_t;

    // Phase within one SCL bit period
    typedef logic [$clog2(`I2C_PHASE_COUNT)-1:0] i2c_phase_t;

endpackage

// ==== design/i2c_seq_pkg.sv ====
package i2c_seq_pkg;

    // Commands from the sequencer to the byte engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2,
        CMD_STOP  = 2'd3
    } byte_cmd_e;

    // Single-register transaction steps
    typedef enum logic [3:0] {
        ST_IDLE    = 4'd0,
        ST_START   = 4'd1,
        ST_ADDR_W  = 4'd2,
        ST_REG     = 4'd3,
        ST_DATA    = 4'd4,
        ST_RESTART = 4'd5,
        ST_ADDR_R  = 4'd6,
        ST_READ    = 4'd7,
        ST_STOP    = 4'd8
    } txn_state_e;

endpackage

// ==== design/i2c_clock_divider.sv ====
`timescale 1ns/10ps

module i2c_clock_divider
    import i2c_bus_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  i2c_divider_t divider,
    output logic         tick
);

    i2c_divider_t count;

    ////////////////////
    // Phase tick counter
    ////////////////////

    // Counts 0..divider, so one tick every divider+1 clocks.
    // The >= compare recovers at once when divider is lowered on the fly
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count >= divider) begin
            count <= '0;
            tick  <= 1'b1;
        end
        else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// ==== design/i2c_byte_engine.sv ====
`timescale 1ns/10ps

`include "i2c_defs.svh"

module i2c_byte_engine
    import i2c_bus_pkg::*;
    import i2c_seq_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      tick,
    input  logic      cmd_valid,
    input  byte_cmd_e cmd,
    input  i2c_data_t tx_byte,
    input  logic      scl_in,
    input  logic      sda_in,
    output logic      scl_low,
    output logic      sda_low,
    output logic      done,
    output logic      ack_ok,
    output i2c_data_t rx_byte
);

    logic                                  active;
    byte_cmd_e                             cur_cmd;
    i2c_phase_t                            phase;
    logic [$clog2(`I2C_BYTE_BITS + 1)-1:0] bit_cnt;
    i2c_data_t                             shift;
    logic                                  accept;
    logic                                  step;
    logic                                  last_bit;
    logic                                  framing;

    assign accept   = cmd_valid && !active;
    assign step     = active && tick;
    // Bit 8 is the ack slot after the data bits
    assign last_bit = (bit_cnt == `I2C_BYTE_BITS);
    assign framing  = (cur_cmd == CMD_START) || (cur_cmd == CMD_STOP);

    ////////////////////
    // Phase sequencing
    ////////////////////

    // Phase 0 sets SDA with SCL low, 1 releases SCL and waits for it,
    // 2 samples with SCL high, 3 pulls SCL low again
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            active  <= 1'b0;
            cur_cmd <= CMD_STOP;
            phase   <= '0;
            bit_cnt <= '0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
            done    <= 1'b0;
            ack_ok  <= 1'b0;
        end
        else begin
            done <= 1'b0;
            if (accept) begin
                active  <= 1'b1;
                cur_cmd <= cmd;
                phase   <= '0;
                bit_cnt <= '0;
            end
            else if (step) begin
                case (phase)
                    2'd0: begin
                        phase <= 2'd1;
                        case (cur_cmd)
                            CMD_START: sda_low <= 1'b0;
                            CMD_STOP:  sda_low <= 1'b1;
                            // Ack slot is released for the target
                            CMD_WRITE: sda_low <= !last_bit && !shift[$left(shift)];
                            // Read bits and the closing NACK leave SDA released
                            default:   sda_low <= 1'b0;
                        endcase
                    end
                    2'd1: begin
                        scl_low <= 1'b0;
                        // Target may stretch SCL here
                        if (!scl_low && scl_in) begin
                            phase <= 2'd2;
                        end
                    end
                    2'd2: begin
                        phase <= 2'd3;
                        if (cur_cmd == CMD_START) begin
                            sda_low <= 1'b1;
                        end
                        else if (cur_cmd == CMD_STOP) begin
                            sda_low <= 1'b0;
                        end
                        else if (cur_cmd == CMD_WRITE && last_bit) begin
                            ack_ok <= !sda_in;
                        end
                    end
                    default: begin
                        phase <= 2'd0;
                        // Bus stays released after STOP
                        if (cur_cmd != CMD_STOP) begin
                            scl_low <= 1'b1;
                        end
                        if (framing || last_bit) begin
                            active <= 1'b0;
                            done   <= 1'b1;
                        end
                        else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Shift register
    ////////////////////

    // Outgoing bits leave at the top while incoming ones enter at the bottom
    always_ff @(posedge clock) begin
        if (accept) begin
            shift <= tx_byte;
        end
        else if (step && phase == 2'd2 && !framing && !last_bit) begin
            shift <= {shift[$left(shift)-1:0], sda_in};
        end
        if (step && phase == 2'd3 && last_bit && cur_cmd == CMD_READ) begin
            rx_byte <= shift;
        end
    end

    // Sequencer must wait for done
    a_no_overlap: assert property (@(posedge clock) disable iff (!reset_n)
        cmd_valid |-> !active);

    // Data only moves under a low clock outside START and STOP
    a_sda_stable: assert property (@(posedge clock) disable iff (!reset_n)
        $changed(sda_low) && !framing |-> scl_low && $past(scl_low));

endmodule

// ==== design/i2c_transaction_fsm.sv ====
`timescale 1ns/10ps

module i2c_transaction_fsm
    import i2c_bus_pkg::*;
    import i2c_seq_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  logic          enable,
    input  logic          read_write,
    input  i2c_data_t     mosi_data,
    input  i2c_reg_addr_t register_address,
    input  i2c_dev_addr_t device_address,
    output logic          busy,
    output logic          nack,
    output i2c_data_t     miso_data,
    output logic          cmd_valid,
    output byte_cmd_e     cmd,
    output i2c_data_t     tx_byte,
    input  logic          done,
    input  logic          ack_ok,
    input  i2c_data_t     rx_byte
);

    txn_state_e    state;
    txn_state_e    next_state;
    logic          issue;
    byte_cmd_e     next_cmd;
    i2c_data_t     next_tx;
    logic          start_request;
    logic          ack_missing;
    logic          saved_read;
    i2c_dev_addr_t saved_device;
    i2c_reg_addr_t saved_register;
    i2c_data_t     saved_data;

    // enable while busy is ignored
    assign start_request = (state == ST_IDLE) && enable;
    assign ack_missing   = done && !ack_ok;

    ////////////////////
    // Next step
    ////////////////////

    always_comb begin
        next_state = state;
        issue      = 1'b0;
        next_cmd   = CMD_STOP;
        next_tx    = tx_byte;
        case (state)
            ST_IDLE: begin
                if (enable) begin
                    next_state = ST_START;
                    issue      = 1'b1;
                    next_cmd   = CMD_START;
                end
            end
            ST_START: begin
                if (done) begin
                    next_state = ST_ADDR_W;
                    issue      = 1'b1;
                    next_cmd   = CMD_WRITE;
                    // Address byte with the write bit
                    next_tx    = {saved_device, 1'b0};
                end
            end
            ST_ADDR_W, ST_REG, ST_ADDR_R: begin
                if (done) begin
                    issue = 1'b1;
                    if (!ack_ok) begin
                        next_state = ST_STOP;
                        next_cmd   = CMD_STOP;
                    end
                    else if (state == ST_ADDR_W) begin
                        next_state = ST_REG;
                        next_cmd   = CMD_WRITE;
                        next_tx    = saved_register;
                    end
                    else if (state == ST_ADDR_R) begin
                        next_state = ST_READ;
                        next_cmd   = CMD_READ;
                    end
                    else if (saved_read) begin
                        next_state = ST_RESTART;
                        next_cmd   = CMD_START;
                    end
                    else begin
                        next_state = ST_DATA;
                        next_cmd   = CMD_WRITE;
                        next_tx    = saved_data;
                    end
                end
            end
            ST_RESTART: begin
                if (done) begin
                    next_state = ST_ADDR_R;
                    issue      = 1'b1;
                    next_cmd   = CMD_WRITE;
                    next_tx    = {saved_device, 1'b1};
                end
            end
            ST_DATA, ST_READ: begin
                if (done) begin
                    next_state = ST_STOP;
                    issue      = 1'b1;
                    next_cmd   = CMD_STOP;
                end
            end
            ST_STOP: begin
                if (done) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            busy      <= 1'b0;
            nack      <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else begin
            state     <= next_state;
            cmd_valid <= issue;
            if (start_request) begin
                busy <= 1'b1;
                nack <= 1'b0;
            end
            else if (state == ST_STOP && done) begin
                busy <= 1'b0;
            end
            if (ack_missing && state inside {ST_ADDR_W, ST_REG, ST_DATA, ST_ADDR_R}) begin
                nack <= 1'b1;
            end
        end
    end

    // Request fields and command payload
    always_ff @(posedge clock) begin
        if (start_request) begin
            saved_read     <= read_write;
            saved_device   <= device_address;
            saved_register <= register_address;
            saved_data     <= mosi_data;
        end
        if (issue) begin
            cmd     <= next_cmd;
            tx_byte <= next_tx;
        end
        if (state == ST_READ && done) begin
            miso_data <= rx_byte;
        end
    end

    // Engine reports only inside a transaction
    a_busy_in_txn: assert property (@(posedge clock) disable iff (!reset_n)
        state != ST_IDLE || done |-> busy);

endmodule

// ==== design/i2c_master.sv ====
`timescale 1ns/10ps

module i2c_master
    import i2c_bus_pkg::*;
    import i2c_seq_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  logic          enable,
    input  logic          read_write,
    input  i2c_data_t     mosi_data,
    input  i2c_reg_addr_t register_address,
    input  i2c_dev_addr_t device_address,
    input  i2c_divider_t  divider,
    output i2c_data_t     miso_data,
    output logic          busy,
    output logic          nack,
    inout  wire           scl,
    inout  wire           sda
);

    logic      tick;
    logic      cmd_valid;
    byte_cmd_e cmd;
    i2c_data_t tx_byte;
    logic      done;
    logic      ack_ok;
    i2c_data_t rx_byte;
    logic      scl_low;
    logic      sda_low;

    // Open drain, high comes from the pull-ups
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

    i2c_clock_divider i_clock_divider (
        .clock   (clock),
        .reset_n (reset_n),
        .divider (divider),
        .tick    (tick)
    );

    i2c_transaction_fsm i_transaction_fsm (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .mosi_data        (mosi_data),
        .register_address (register_address),
        .device_address   (device_address),
        .busy             (busy),
        .nack             (nack),
        .miso_data        (miso_data),
        .cmd_valid        (cmd_valid),
        .cmd              (cmd),
        .tx_byte          (tx_byte),
        .done             (done),
        .ack_ok           (ack_ok),
        .rx_byte          (rx_byte)
    );

    i2c_byte_engine i_byte_engine (
        .clock     (clock),
        .reset_n   (reset_n),
        .tick      (tick),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .scl_in    (scl),
        .sda_in    (sda),
        .scl_low   (scl_low),
        .sda_low   (sda_low),
        .done      (done),
        .ack_ok    (ack_ok),
        .rx_byte   (rx_byte)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Reset held for 16 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clock);
        #2 reset_n = 1'b1;
    end

endmodule

// ==== verification/tb_i2c_target.sv ====
`timescale 1ns/10ps

module tb_i2c_target (
    inout  wire        scl,
    inout  wire        sda,
    input  logic [6:0] own_address,
    input  logic       stretch_enable,
    input  int         stretch_ns
);

    typedef enum int {T_IDLE, T_ADDR, T_REG, T_WRITE, T_READ} stage_e;

    logic [7:0] mem [256];
    logic       sda_pull;
    logic       scl_pull;
    logic       read_req;
    stage_e     stage;
    int         bit_idx;
    logic [7:0] shift_in;
    logic [7:0] shift_out;
    logic [7:0] reg_ptr;

    assign scl = scl_pull ? 1'b0 : 1'bz;
    assign sda = sda_pull ? 1'b0 : 1'bz;

    initial begin
        sda_pull = 1'b0;
        scl_pull = 1'b0;
        read_req = 1'b0;
        stage    = T_IDLE;
        bit_idx  = 0;
        reg_ptr  = 8'h00;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i[7:0] * 8'd29) ^ 8'h96;
        end
    end

    ////////////////////
    // Bus conditions
    ////////////////////

    always @(negedge sda) begin
        if (scl === 1'b1) begin
            stage    = T_ADDR;
            bit_idx  = 0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            stage    = T_IDLE;
            sda_pull = 1'b0;
        end
    end

    ////////////////////
    // Bit handling
    ////////////////////

    always @(posedge scl) begin
        if (stage != T_IDLE) begin
            if (bit_idx < 8) begin
                shift_in = {shift_in[6:0], sda === 1'b1};
            end
            else if (stage == T_READ && sda === 1'b1) begin
                // Master NACK closes the read
                stage = T_IDLE;
            end
            bit_idx++;
        end
    end

    always @(negedge scl) begin
        if (stage == T_READ && bit_idx < 9) begin
            sda_pull = (bit_idx < 8) ? !shift_out[7 - bit_idx] : 1'b0;
        end
        else if (stage != T_IDLE && bit_idx == 8) begin
            take_byte();
        end
        else if (stage != T_IDLE && bit_idx == 9) begin
            next_byte();
        end
    end

    // Ack slot decision for a received byte
    task automatic take_byte();
        if (stage == T_ADDR && shift_in[7:1] != own_address) begin
            stage = T_IDLE;
        end
        else begin
            if (stage == T_ADDR) begin
                read_req = shift_in[0];
            end
            else if (stage == T_REG) begin
                reg_ptr = shift_in;
            end
            else begin
                mem[reg_ptr] = shift_in;
                reg_ptr      = reg_ptr + 8'd1;
            end
            sda_pull = 1'b1;
        end
    endtask

    task automatic next_byte();
        sda_pull = 1'b0;
        bit_idx  = 0;
        if (stage == T_ADDR) begin
            stage = read_req ? T_READ : T_REG;
        end
        else if (stage == T_REG) begin
            stage = T_WRITE;
        end
        else if (stage == T_READ) begin
            reg_ptr = reg_ptr + 8'd1;
        end
        if (stage == T_READ) begin
            shift_out = mem[reg_ptr];
            sda_pull  = !shift_out[7];
        end
        // Hold SCL low between bytes
        if (stretch_enable) begin
            scl_pull = 1'b1;
            #(stretch_ns);
            scl_pull = 1'b0;
        end
    endtask

endmodule

// ==== verification/tb_scoreboard.sv ====
`timescale 1ns/10ps

module tb_scoreboard (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       enable,
    input  logic       busy,
    input  logic       nack,
    input  logic [7:0] miso_data,
    input  wire        scl,
    input  wire        sda,
    input  logic       check_miso,
    input  logic [7:0] exp_miso,
    input  logic       exp_nack,
    input  logic       report,
    output int         test_count,
    output int         fail_count
);

    logic busy_seen;
    logic enable_seen;
    logic reset_checked;
    int   errors;

    initial begin
        test_count    = 0;
        fail_count    = 0;
        busy_seen     = 1'b0;
        enable_seen   = 1'b0;
        reset_checked = 1'b0;
    end

    task automatic compare_value(input string name, input logic [7:0] actual,
                                 input logic [7:0] expected, inout int count);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%02h, got 0x%02h", name, expected, actual);
            count++;
        end
    endtask

    task automatic finish_test(input string label, input int count);
        test_count++;
        if (count != 0) begin
            fail_count++;
        end
        $display("Test %0d %s: %s", test_count, label, (count == 0) ? "ok" : "mismatch");
    endtask

    // DUT outputs move on the rising edge, so look at the falling one
    always @(negedge clock) begin
        if (reset_n === 1'b1 && !reset_checked) begin
            reset_checked = 1'b1;
            errors        = 0;
            compare_value("busy", busy, 8'h00, errors);
            compare_value("nack", nack, 8'h00, errors);
            compare_value("scl", scl, 8'h01, errors);
            compare_value("sda", sda, 8'h01, errors);
            finish_test("reset", errors);
        end
        else if (reset_checked) begin
            if (busy === 1'b1 && !busy_seen && !enable_seen) begin
                $display("Transaction started with no enable request");
                fail_count++;
            end
            if (busy_seen && busy === 1'b0) begin
                errors = 0;
                compare_value("nack", nack, exp_nack, errors);
                if (check_miso) begin
                    compare_value("miso_data", miso_data, exp_miso, errors);
                end
                // Bus must be released after STOP
                compare_value("scl", scl, 8'h01, errors);
                compare_value("sda", sda, 8'h01, errors);
                finish_test("transaction", errors);
            end
            busy_seen = (busy === 1'b1);
        end
        enable_seen = (enable === 1'b1);
    end

    always @(posedge report) begin
        $display("Tests run %0d, failed %0d", test_count, fail_count);
    end

endmodule

// ==== verification/tb_i2c_master.sv ====
`timescale 1ns/10ps

module tb_i2c_master;

    localparam logic [6:0]  TARGET_ADDRESS = 7'h50;
    localparam logic [6:0]  OTHER_ADDRESS  = 7'h2c;
    localparam int          STRETCH_NS     = 740;
    localparam int          WAIT_CYCLES    = 20000;
    localparam logic [31:0] LFSR_SEED      = 32'hae807d5a;
    localparam int          MAX_ROWS       = 32;

    typedef struct packed {
        logic       rw;
        logic [6:0] dev;
        logic [7:0] reg_addr;
        logic [7:0] data;
        logic       stretch;
        logic       again;
        logic [7:0] exp_miso;
        logic       exp_nack;
    } row_t;

    logic        clock;
    logic        reset_n;
    logic        enable;
    logic        read_write;
    logic [7:0]  mosi_data;
    logic [7:0]  register_address;
    logic [6:0]  device_address;
    logic [15:0] divider;
    logic [7:0]  miso_data;
    logic        busy;
    logic        nack;
    wire         scl;
    wire         sda;
    logic        stretch_enable;
    logic        check_miso;
    logic [7:0]  exp_miso;
    logic        exp_nack;
    logic        report;
    int          test_count;
    int          fail_count;
    logic [31:0] lfsr;
    logic [7:0]  model_mem [256];
    row_t        table_rows [MAX_ROWS];
    int          row_count;

    pullup (scl);
    pullup (sda);

    tb_clock_gen i_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    i2c_master i_dut (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .mosi_data        (mosi_data),
        .register_address (register_address),
        .device_address   (device_address),
        .divider          (divider),
        .miso_data        (miso_data),
        .busy             (busy),
        .nack             (nack),
        .scl              (scl),
        .sda              (sda)
    );

    tb_i2c_target i_target (
        .scl            (scl),
        .sda            (sda),
        .own_address    (TARGET_ADDRESS),
        .stretch_enable (stretch_enable),
        .stretch_ns     (STRETCH_NS)
    );

    tb_scoreboard i_scoreboard (
        .clock      (clock),
        .reset_n    (reset_n),
        .enable     (enable),
        .busy       (busy),
        .nack       (nack),
        .miso_data  (miso_data),
        .scl        (scl),
        .sda        (sda),
        .check_miso (check_miso),
        .exp_miso   (exp_miso),
        .exp_nack   (exp_nack),
        .report     (report),
        .test_count (test_count),
        .fail_count (fail_count)
    );

    ////////////////////
    // Stimulus table
    ////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = 8'h00;
        repeat (8) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
        return value;
    endfunction

    // Power-up contents of the target memory
    function automatic logic [7:0] fill_byte(input logic [7:0] addr);
        return (addr * 8'd29) ^ 8'h96;
    endfunction

    task automatic add_row(input logic rw, input logic [6:0] dev, input logic [7:0] reg_addr,
                           input logic [7:0] data, input logic stretch, input logic again);
        row_t row;
        row.rw       = rw;
        row.dev      = dev;
        row.reg_addr = reg_addr;
        row.data     = data;
        row.stretch  = stretch;
        row.again    = again;
        row.exp_nack = (dev != TARGET_ADDRESS);
        row.exp_miso = model_mem[reg_addr];
        if (!rw && !row.exp_nack) begin
            model_mem[reg_addr] = data;
        end
        table_rows[row_count] = row;
        row_count++;
    endtask

    task automatic build_table();
        logic [7:0] reg_addr;
        logic [7:0] data;
        add_row(1'b0, TARGET_ADDRESS, 8'h3c, 8'ha5, 1'b0, 1'b0);
        add_row(1'b1, TARGET_ADDRESS, 8'h3c, 8'h00, 1'b0, 1'b0);
        repeat (4) begin
            reg_addr = random_byte();
            data     = random_byte();
            add_row(1'b0, TARGET_ADDRESS, reg_addr, data, 1'b0, 1'b0);
            add_row(1'b1, TARGET_ADDRESS, reg_addr, 8'h00, 1'b0, 1'b0);
        end
        // Unknown device, register must keep its value
        add_row(1'b0, OTHER_ADDRESS, 8'h3c, 8'h11, 1'b0, 1'b0);
        add_row(1'b1, OTHER_ADDRESS, 8'h3c, 8'h00, 1'b0, 1'b0);
        add_row(1'b1, TARGET_ADDRESS, 8'h3c, 8'h00, 1'b0, 1'b0);
        // Target stretches SCL
        data = random_byte();
        add_row(1'b0, TARGET_ADDRESS, 8'h81, data, 1'b1, 1'b0);
        add_row(1'b1, TARGET_ADDRESS, 8'h81, 8'h00, 1'b1, 1'b0);
        add_row(1'b1, TARGET_ADDRESS, 8'hf0, 8'h00, 1'b1, 1'b0);
        // Second enable while busy touches nothing
        add_row(1'b0, TARGET_ADDRESS, 8'h20, 8'h5e, 1'b0, 1'b1);
        add_row(1'b1, TARGET_ADDRESS, 8'h20, 8'h00, 1'b0, 1'b0);
        add_row(1'b1, TARGET_ADDRESS, 8'h21, 8'h00, 1'b0, 1'b0);
    endtask

    ////////////////////
    // Apply loop
    ////////////////////

    task automatic wait_for_count(input int target, output logic ok);
        int waited;
        waited = 0;
        while (test_count < target && waited < WAIT_CYCLES) begin
            @(posedge clock);
            #2;
            waited++;
        end
        ok = (test_count >= target);
        if (!ok) begin
            $display("Scoreboard did not finish test %0d in time", target);
        end
    endtask

    task automatic run_row(input row_t row, input int number, output logic ok);
        int waited;
        ok = 1'b1;
        @(posedge clock);
        #2;
        exp_miso         = row.exp_miso;
        exp_nack         = row.exp_nack;
        check_miso       = row.rw && !row.exp_nack;
        stretch_enable   = row.stretch;
        read_write       = row.rw;
        device_address   = row.dev;
        register_address = row.reg_addr;
        mosi_data        = row.data;
        enable           = 1'b1;
        waited           = 0;
        while (busy !== 1'b1 && waited < WAIT_CYCLES) begin
            @(posedge clock);
            #2;
            waited++;
        end
        enable = 1'b0;
        if (busy !== 1'b1) begin
            $display("Test %0d: busy never rose after enable", number);
            ok = 1'b0;
        end
        else begin
            if (row.again) begin
                repeat (3) begin
                    @(posedge clock);
                    #2;
                end
                mosi_data        = ~row.data;
                register_address = row.reg_addr + 8'd1;
                enable           = 1'b1;
                @(posedge clock);
                #2;
                enable = 1'b0;
            end
            waited = 0;
            while (busy !== 1'b0 && waited < WAIT_CYCLES) begin
                @(posedge clock);
                #2;
                waited++;
            end
            if (busy !== 1'b0) begin
                $display("Test %0d: busy stayed high, transaction never ended", number);
                ok = 1'b0;
            end
        end
    endtask

    initial begin
        logic ok;
        int   n;
        enable           = 1'b0;
        read_write       = 1'b0;
        mosi_data        = 8'h00;
        register_address = 8'h00;
        device_address   = 7'h00;
        divider          = 16'd4;
        stretch_enable   = 1'b0;
        check_miso       = 1'b0;
        exp_miso         = 8'h00;
        exp_nack         = 1'b0;
        report           = 1'b0;
        lfsr             = LFSR_SEED;
        row_count        = 0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = fill_byte(i[7:0]);
        end
        build_table();
        // Test 1 is the reset check
        wait_for_count(1, ok);
        n = 0;
        while (ok && n < row_count) begin
            run_row(table_rows[n], n + 2, ok);
            if (ok) begin
                wait_for_count(n + 2, ok);
            end
            n++;
        end
        report = 1'b1;
        #1;
        if (ok && fail_count == 0 && test_count == row_count + 1) begin
            $display("Testbench passed");
        end
        else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/i2c_bus_pkg.sv
design/i2c_seq_pkg.sv
design/i2c_clock_divider.sv
design/i2c_byte_engine.sv
design/i2c_transaction_fsm.sv
design/i2c_master.sv
verification/tb_clock_gen.sv
verification/tb_i2c_target.sv
verification/tb_scoreboard.sv
verification/tb_i2c_master.sv
